// File: hdl/stream_pipe_pkg.sv
`default_nettype none

package stream_pipe_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    // One phit of stream or inbound data
    localparam int PHIT_W = 32;

    // Register file per column, 16 words
    localparam int RF_ADDR_W = 4;
    localparam int RF_DEPTH  = 2 ** RF_ADDR_W;

    // Output item counter, wraps
    localparam int CNT_W = 16;

    //////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////

    // ALU ops, all zero is ADD
    typedef enum logic [1:0] {
        OP_ADD  = 2'd0,
        OP_SUB  = 2'd1,
        OP_XOR  = 2'd2,
        OP_PASS = 2'd3
    } alu_op_e;

    // Operand sources for a and b
    typedef enum logic [1:0] {
        SRC_STREAM  = 2'd0,
        SRC_INBOUND = 2'd1,
        SRC_IMM     = 2'd2,
        SRC_RF      = 2'd3
    } operand_sel_e;

    //////////////////////////////////////////////////
    // Structs
    //////////////////////////////////////////////////

    // Column control word, op in the top bits
    typedef struct packed {
        alu_op_e                op;
        operand_sel_e           sel_a;
        operand_sel_e           sel_b;
        logic                   wen_rf;
        logic [RF_ADDR_W-1:0]   rf_addr;
    } col_ctrl_t;

    // Control word width as stored in program memory
    localparam int CTRL_W = $bits(col_ctrl_t);

    // One item between columns
    typedef struct packed {
        logic               valid;
        logic [PHIT_W-1:0]  inbound;
        logic [PHIT_W-1:0]  data;
    } phit_item_t;

    // Result state word
    typedef struct packed {
        logic [CNT_W-1:0]   item_count;
        logic [PHIT_W-1:0]  checksum;
    } pipe_state_t;

endpackage

`default_nettype wire

// File: hdl/ctrl_plane.sv
`default_nettype none

module ctrl_plane #(
    parameter int NUM_COL    = 4,
    parameter int PROG_DEPTH = 8
) (
    input  logic                                            clk,
    input  logic                                            arst_n,
    input  logic [$clog2(PROG_DEPTH)-1:0]                   prog_sel,
    input  logic [$clog2(PROG_DEPTH)-1:0]                   cfg_wr_addr,
    input  logic [NUM_COL-1:0]                              cfg_wr_en,
    input  logic [stream_pipe_pkg::PHIT_W-1:0]              cfg_wr_data,
    output stream_pipe_pkg::col_ctrl_t [NUM_COL-2:0]        col_ctrl,
    output logic [NUM_COL-2:0][stream_pipe_pkg::PHIT_W-1:0] col_imm
);

    localparam int NCOL   = NUM_COL - 1;
    localparam int PHIT_W = stream_pipe_pkg::PHIT_W;
    localparam int CTRL_W = stream_pipe_pkg::CTRL_W;

    // Top enable bit routes the write to immediates
    logic imm_wr;
    // One enable bit per column
    logic [NCOL-1:0] col_wr;
    // Write lands on the row being read out
    logic sel_hit;

    // Program memories, one row per program per column
    logic [CTRL_W-1:0] ctrl_mem [NCOL][PROG_DEPTH];
    logic [PHIT_W-1:0] imm_mem [NCOL][PROG_DEPTH];

    // Next readout, memory row or bypassed write data
    logic [NCOL-1:0][CTRL_W-1:0] ctrl_row;
    logic [NCOL-1:0][PHIT_W-1:0] imm_row;

    assign imm_wr  = cfg_wr_en[NUM_COL-1];
    assign col_wr  = cfg_wr_en[NUM_COL-2:0];
    assign sel_hit = (cfg_wr_addr == prog_sel);

    //////////////////////////////////////////////////
    // Configuration writes
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // Zeroed control is ADD of stream plus stream, no RF write
            for (int c = 0; c < NCOL; c++) begin
                for (int a = 0; a < PROG_DEPTH; a++) begin
                    ctrl_mem[c][a] <= '0;
                    imm_mem[c][a]  <= '0;
                end
            end
        end else begin
            for (int c = 0; c < NCOL; c++) begin
                if (col_wr[c]) begin
                    if (imm_wr) begin
                        imm_mem[c][cfg_wr_addr] <= cfg_wr_data;
                    end else begin
                        // Control word in the low bits only
                        ctrl_mem[c][cfg_wr_addr] <= cfg_wr_data[CTRL_W-1:0];
                    end
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Program readout and decode
    //////////////////////////////////////////////////

    // Bypass so a write to the live row shows one cycle later
    always_comb begin
        for (int c = 0; c < NCOL; c++) begin
            ctrl_row[c] = ctrl_mem[c][prog_sel];
            imm_row[c]  = imm_mem[c][prog_sel];
            if (col_wr[c] && sel_hit) begin
                if (imm_wr) begin
                    imm_row[c] = cfg_wr_data;
                end else begin
                    ctrl_row[c] = cfg_wr_data[CTRL_W-1:0];
                end
            end
        end
    end

    // Registered rows, cast into the control struct
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_ctrl <= '0;
            col_imm  <= '0;
        end else begin
            for (int c = 0; c < NCOL; c++) begin
                col_ctrl[c] <= stream_pipe_pkg::col_ctrl_t'(ctrl_row[c]);
                col_imm[c]  <= imm_row[c];
            end
        end
    end

    // Immediate write must target at least one column
    a_imm_wr_has_col: assert property (
        @(posedge clk) disable iff (!arst_n)
        imm_wr |-> (|col_wr)
    ) else $error("immediate write with no column selected");

endmodule

`default_nettype wire

// File: hdl/column_stage.sv
`default_nettype none

module column_stage (
    input  logic                               clk,
    input  logic                               arst_n,
    input  stream_pipe_pkg::phit_item_t        item_in,
    input  stream_pipe_pkg::col_ctrl_t         ctrl,
    input  logic [stream_pipe_pkg::PHIT_W-1:0] imm,
    output stream_pipe_pkg::phit_item_t        item_out
);

    localparam int PHIT_W   = stream_pipe_pkg::PHIT_W;
    localparam int RF_DEPTH = stream_pipe_pkg::RF_DEPTH;

    // Column register file
    logic [PHIT_W-1:0] rf [RF_DEPTH];

    // Old RF word at rf_addr
    logic [PHIT_W-1:0] rf_rd;
    // Selected operands
    logic [PHIT_W-1:0] opd_a;
    logic [PHIT_W-1:0] opd_b;
    // ALU output
    logic [PHIT_W-1:0] alu_res;
    // Only valid items write back
    logic rf_wr;

    // Output item registers
    logic              valid_q;
    logic [PHIT_W-1:0] inbound_q;
    logic [PHIT_W-1:0] data_q;

    //////////////////////////////////////////////////
    // Operand select
    //////////////////////////////////////////////////

    function automatic logic [PHIT_W-1:0] pick_operand(
        input stream_pipe_pkg::operand_sel_e sel,
        input logic [PHIT_W-1:0]             stream_w,
        input logic [PHIT_W-1:0]             inbound_w,
        input logic [PHIT_W-1:0]             imm_w,
        input logic [PHIT_W-1:0]             rf_w
    );
        logic [PHIT_W-1:0] res;
        case (sel)
            stream_pipe_pkg::SRC_STREAM:  res = stream_w;
            stream_pipe_pkg::SRC_INBOUND: res = inbound_w;
            stream_pipe_pkg::SRC_IMM:     res = imm_w;
            default:                      res = rf_w;
        endcase
        return res;
    endfunction

    // Read before write, same address for both
    assign rf_rd = rf[ctrl.rf_addr];

    assign opd_a = pick_operand(ctrl.sel_a, item_in.data, item_in.inbound, imm, rf_rd);
    assign opd_b = pick_operand(ctrl.sel_b, item_in.data, item_in.inbound, imm, rf_rd);

    //////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////

    always_comb begin
        case (ctrl.op)
            stream_pipe_pkg::OP_ADD: alu_res = opd_a + opd_b;
            stream_pipe_pkg::OP_SUB: alu_res = opd_a - opd_b;
            stream_pipe_pkg::OP_XOR: alu_res = opd_a ^ opd_b;
            // PASS forwards a
            default:                 alu_res = opd_a;
        endcase
    end

    // Bubbles never touch the RF
    assign rf_wr = item_in.valid && ctrl.wen_rf;

    //////////////////////////////////////////////////
    // Register file and output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < RF_DEPTH; i++) begin
                rf[i] <= '0;
            end
        end else if (rf_wr) begin
            rf[ctrl.rf_addr] <= alu_res;
        end
    end

    // Valid carried, cleared on reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= item_in.valid;
        end
    end

    // Payload, qualified downstream by valid
    always_ff @(posedge clk) begin
        inbound_q <= item_in.inbound;
        data_q    <= alu_res;
    end

    assign item_out.valid   = valid_q;
    assign item_out.inbound = inbound_q;
    assign item_out.data    = data_q;

    // Control from the plane is settled whenever an item arrives
    a_op_known: assert property (
        @(posedge clk) disable iff (!arst_n)
        item_in.valid |-> !$isunknown(ctrl.op)
    ) else $error("unknown ALU op on a valid item");

endmodule

`default_nettype wire

// File: hdl/stream_result.sv
`default_nettype none

module stream_result (
    input  logic                               clk,
    input  logic                               arst_n,
    input  stream_pipe_pkg::phit_item_t        item_in,
    output logic                               out_valid,
    output logic [stream_pipe_pkg::PHIT_W-1:0] stream_out,
    output stream_pipe_pkg::pipe_state_t       state
);

    localparam int PHIT_W = stream_pipe_pkg::PHIT_W;

    // Output strobe
    logic valid_q;
    // Output data word
    logic [PHIT_W-1:0] data_q;
    // Count and checksum
    stream_pipe_pkg::pipe_state_t state_q;

    //////////////////////////////////////////////////
    // Output and state registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            state_q <= '0;
        end else begin
            valid_q <= item_in.valid;
            // State moves on the same edge that raises out_valid
            if (item_in.valid) begin
                state_q.item_count <= state_q.item_count + 1'b1;
                state_q.checksum   <= state_q.checksum ^ item_in.data;
            end
        end
    end

    // Data word, meaningful only with out_valid
    always_ff @(posedge clk) begin
        data_q <= item_in.data;
    end

    assign out_valid  = valid_q;
    assign stream_out = data_q;
    assign state      = state_q;

endmodule

`default_nettype wire

// File: hdl/stream_pipe_top.sv
`default_nettype none

module stream_pipe_top #(
    parameter int NUM_COL    = 4,
    parameter int PROG_DEPTH = 8
) (
    input  logic                               clk,
    input  logic                               arst_n,
    // Item input, single-cycle strobe
    input  logic                               in_valid,
    input  logic [stream_pipe_pkg::PHIT_W-1:0] inbound,
    input  logic [stream_pipe_pkg::PHIT_W-1:0] stream_in,
    // Program select and configuration port
    input  logic [$clog2(PROG_DEPTH)-1:0]      prog_sel,
    input  logic [$clog2(PROG_DEPTH)-1:0]      cfg_wr_addr,
    input  logic [NUM_COL-1:0]                 cfg_wr_en,
    input  logic [stream_pipe_pkg::PHIT_W-1:0] cfg_wr_data,
    // Result
    output logic                               out_valid,
    output logic [stream_pipe_pkg::PHIT_W-1:0] stream_out,
    output stream_pipe_pkg::pipe_state_t       state
);

    localparam int PHIT_W = stream_pipe_pkg::PHIT_W;

    // Decoded program, one entry per column
    stream_pipe_pkg::col_ctrl_t [NUM_COL-2:0] col_ctrl;
    logic [NUM_COL-2:0][PHIT_W-1:0]           col_imm;

    // item[c] feeds column c, last entry feeds the result stage
    stream_pipe_pkg::phit_item_t [NUM_COL-1:0] item;

    //////////////////////////////////////////////////
    // Control plane
    //////////////////////////////////////////////////

    ctrl_plane #(
        .NUM_COL    (NUM_COL),
        .PROG_DEPTH (PROG_DEPTH)
    ) i_ctrl_plane (
        .clk         (clk),
        .arst_n      (arst_n),
        .prog_sel    (prog_sel),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_data (cfg_wr_data),
        .col_ctrl    (col_ctrl),
        .col_imm     (col_imm)
    );

    //////////////////////////////////////////////////
    // Columns
    //////////////////////////////////////////////////

    // Input item into column 0
    assign item[0] = '{valid: in_valid, inbound: inbound, data: stream_in};

    for (genvar c = 0; c < NUM_COL - 1; c++) begin : g_col
        column_stage i_column_stage (
            .clk      (clk),
            .arst_n   (arst_n),
            .item_in  (item[c]),
            .ctrl     (col_ctrl[c]),
            .imm      (col_imm[c]),
            .item_out (item[c+1])
        );
    end

    // Result register and state
    stream_result i_stream_result (
        .clk        (clk),
        .arst_n     (arst_n),
        .item_in    (item[NUM_COL-1]),
        .out_valid  (out_valid),
        .stream_out (stream_out),
        .state      (state)
    );

endmodule

`default_nettype wire

// File: tb/tb_stream_pipe.sv
`default_nettype none

module tb_stream_pipe;

    localparam int NUM_COL    = 4;
    localparam int PROG_DEPTH = 8;
    localparam int NCOL       = NUM_COL - 1;
    localparam int SEL_W      = $clog2(PROG_DEPTH);

    // Items per burst in each test
    localparam int N_OPS = 6;
    localparam int N_ACC = 10;
    localparam int N_SW  = 8;
    localparam int N_MIX = 40;
    // Run bound: reset, 42 config writes of 2 cycles, all items, 10 bursts with hold and drain
    localparam int WD_CYCLES = 10 + 2 * 42 + (1 + 4 * N_OPS + N_ACC + 3 * N_SW + N_MIX)
                             + 10 * (8 + NUM_COL) + 200;

    logic                    clk;
    logic                    arst_n;
    logic                    in_valid;
    logic [31:0]             inbound;
    logic [31:0]             stream_in;
    logic [SEL_W-1:0]        prog_sel;
    logic [SEL_W-1:0]        cfg_wr_addr;
    logic [NUM_COL-1:0]      cfg_wr_en;
    logic [31:0]             cfg_wr_data;
    logic                    out_valid;
    logic [31:0]             stream_out;
    stream_pipe_pkg::pipe_state_t state;

    // Reference model state
    logic [10:0] m_ctrl [NCOL][PROG_DEPTH];
    logic [31:0] m_imm [NCOL][PROG_DEPTH];
    logic [31:0] m_rf [NCOL][16];
    logic [SEL_W-1:0] m_sel;
    logic [15:0] m_count;
    logic [31:0] m_csum;

    // Expected outputs and the cycle each is due
    logic [31:0] exp_q[$];
    int          exp_cyc_q[$];
    logic [31:0] mon_exp;
    int          mon_cyc;

    logic [31:0] lfsr;
    int    cyc;
    string cur_test;
    int    test_err;
    int    sent_cnt;
    int    seen_cnt;
    int    pass_cnt;
    int    fail_cnt;

    stream_pipe_top #(
        .NUM_COL    (NUM_COL),
        .PROG_DEPTH (PROG_DEPTH)
    ) i_stream_pipe_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .inbound     (inbound),
        .stream_in   (stream_in),
        .prog_sel    (prog_sel),
        .cfg_wr_addr (cfg_wr_addr),
        .cfg_wr_en   (cfg_wr_en),
        .cfg_wr_data (cfg_wr_data),
        .out_valid   (out_valid),
        .stream_out  (stream_out),
        .state       (state)
    );

    always #10 clk = ~clk;

    // Cycle count, stable between edges
    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // Random bits and reference model
    //////////////////////////////////////////////////

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Control word as it sits in cfg_wr_data
    function automatic logic [31:0] make_ctrl(input logic [1:0] op, input logic [1:0] sa,
                                              input logic [1:0] sb, input logic wen,
                                              input logic [3:0] addr);
        return {21'b0, op, sa, sb, wen, addr};
    endfunction

    function automatic logic [31:0] pick_src(input logic [1:0] sel, input logic [31:0] d,
                                             input logic [31:0] inb, input logic [31:0] imm,
                                             input logic [31:0] rd);
        case (sel)
            stream_pipe_pkg::SRC_STREAM:  return d;
            stream_pipe_pkg::SRC_INBOUND: return inb;
            stream_pipe_pkg::SRC_IMM:     return imm;
            default:                      return rd;
        endcase
    endfunction

    // Push one item through all columns, RF writes in item order
    function automatic logic [31:0] model_item(input logic [31:0] data, input logic [31:0] inb);
        logic [10:0] w;
        logic [31:0] d;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rd;
        logic [31:0] r;
        d = data;
        for (int c = 0; c < NCOL; c++) begin
            w  = m_ctrl[c][m_sel];
            // Old RF word, read before write
            rd = m_rf[c][w[3:0]];
            a  = pick_src(w[8:7], d, inb, m_imm[c][m_sel], rd);
            b  = pick_src(w[6:5], d, inb, m_imm[c][m_sel], rd);
            case (w[10:9])
                stream_pipe_pkg::OP_ADD: r = a + b;
                stream_pipe_pkg::OP_SUB: r = a - b;
                stream_pipe_pkg::OP_XOR: r = a ^ b;
                default:                 r = a;
            endcase
            if (w[4]) m_rf[c][w[3:0]] = r;
            d = r;
        end
        return d;
    endfunction

    //////////////////////////////////////////////////
    // Drive tasks
    //////////////////////////////////////////////////

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // Top enable bit picks the immediate memory
    task automatic cfg_write(input logic [NUM_COL-1:0] en, input logic [SEL_W-1:0] addr,
                             input logic [31:0] data);
        tick();
        cfg_wr_en   = en;
        cfg_wr_addr = addr;
        cfg_wr_data = data;
        for (int c = 0; c < NCOL; c++) begin
            if (en[c] && en[NUM_COL-1]) m_imm[c][addr] = data;
            else if (en[c]) m_ctrl[c][addr] = data[10:0];
        end
        tick();
        cfg_wr_en = '0;
    endtask

    task automatic write_col(input int col, input logic [SEL_W-1:0] addr,
                             input logic [31:0] ctrl, input logic [31:0] imm);
        logic [NUM_COL-1:0] en;
        en      = '0;
        en[col] = 1'b1;
        cfg_write(en, addr, ctrl);
        en[NUM_COL-1] = 1'b1;
        cfg_write(en, addr, imm);
    endtask

    // New program, then two quiet cycles before items
    task automatic set_prog(input logic [SEL_W-1:0] sel);
        tick();
        prog_sel = sel;
        m_sel    = sel;
        tick();
        tick();
    endtask

    task automatic send_item(input logic v, input logic [31:0] d, input logic [31:0] inb);
        logic [31:0] e;
        tick();
        in_valid  = v;
        stream_in = d;
        inbound   = inb;
        if (v) begin
            e = model_item(d, inb);
            exp_q.push_back(e);
            exp_cyc_q.push_back(cyc + NUM_COL);
            m_count  = m_count + 16'd1;
            m_csum   = m_csum ^ e;
            sent_cnt = sent_cnt + 1;
        end
    endtask

    task automatic send_burst(input int n);
        for (int i = 0; i < n; i++) send_item(1'b1, take_bits(32), take_bits(32));
        tick();
        in_valid = 1'b0;
    endtask

    // Wait for outstanding outputs, bounded by the pipe depth
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() > 0 && waited < NUM_COL + 4) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() > 0) begin
            $display("%s: %0d expected outputs never appeared on out_valid",
                     cur_test, exp_q.size());
            test_err++;
            exp_q.delete();
            exp_cyc_q.delete();
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err = 0;
        sent_cnt = 0;
        seen_cnt = 0;
    endtask

    task automatic end_test();
        if (test_err == 0) begin
            $display("test %s: ok", cur_test);
            pass_cnt++;
        end else begin
            $display("test %s: %0d errors", cur_test, test_err);
            fail_cnt++;
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    // Sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (arst_n && out_valid) begin
            seen_cnt++;
            if (exp_q.size() == 0) begin
                $display("%s: out_valid high with no item outstanding", cur_test);
                test_err++;
            end else begin
                mon_exp = exp_q.pop_front();
                mon_cyc = exp_cyc_q.pop_front();
                if (stream_out !== mon_exp) begin
                    $display("ERR %s: expected %h, actual %h", cur_test, mon_exp, stream_out);
                    test_err++;
                end
                if (cyc != mon_cyc) begin
                    $display("%s: output came at cycle %0d, due at cycle %0d",
                             cur_test, cyc, mon_cyc);
                    test_err++;
                end
            end
        end
    end

    //////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////

    task automatic test_reset_defaults();
        start_test("reset_defaults");
        if (out_valid !== 1'b0) begin
            $display("ERR %s: expected %h, actual %h", cur_test, 1'b0, out_valid);
            test_err++;
        end
        if (state !== '0) begin
            $display("ERR %s: expected %h, actual %h", cur_test, 48'h0, state);
            test_err++;
        end
        // Zeroed programs add the stream word to itself
        send_burst(1);
        drain();
        end_test();
    endtask

    // Ops rotate over columns, sel_a walks all four sources
    task automatic test_operand_ops();
        start_test("operand_ops");
        for (int p = 0; p < 4; p++) begin
            for (int c = 0; c < NCOL; c++) begin
                write_col(c, SEL_W'(p + 1),
                          make_ctrl(2'((p + c) % 4), 2'(p), 2'((p + c + 1) % 4), 1'b1, 4'(p)),
                          take_bits(32));
            end
        end
        for (int p = 0; p < 4; p++) begin
            set_prog(SEL_W'(p + 1));
            send_burst(N_OPS);
            drain();
        end
        end_test();
    endtask

    // Column 0 accumulates into RF 9, later columns pass
    task automatic test_rf_accum();
        start_test("rf_accum");
        write_col(0, 3'd5, make_ctrl(stream_pipe_pkg::OP_ADD, stream_pipe_pkg::SRC_RF,
                                     stream_pipe_pkg::SRC_STREAM, 1'b1, 4'd9), 32'h0);
        for (int c = 1; c < NCOL; c++) begin
            write_col(c, 3'd5, make_ctrl(stream_pipe_pkg::OP_PASS, stream_pipe_pkg::SRC_STREAM,
                                         stream_pipe_pkg::SRC_STREAM, 1'b0, 4'd0), 32'h0);
        end
        set_prog(3'd5);
        send_burst(N_ACC);
        drain();
        end_test();
    endtask

    task automatic test_prog_switch();
        start_test("prog_switch");
        write_col(0, 3'd6, make_ctrl(stream_pipe_pkg::OP_XOR, stream_pipe_pkg::SRC_STREAM,
                                     stream_pipe_pkg::SRC_IMM, 1'b0, 4'd0), take_bits(32));
        write_col(1, 3'd6, make_ctrl(stream_pipe_pkg::OP_SUB, stream_pipe_pkg::SRC_STREAM,
                                     stream_pipe_pkg::SRC_INBOUND, 1'b0, 4'd0), take_bits(32));
        write_col(2, 3'd6, make_ctrl(stream_pipe_pkg::OP_ADD, stream_pipe_pkg::SRC_STREAM,
                                     stream_pipe_pkg::SRC_IMM, 1'b0, 4'd0), take_bits(32));
        write_col(0, 3'd7, make_ctrl(stream_pipe_pkg::OP_SUB, stream_pipe_pkg::SRC_IMM,
                                     stream_pipe_pkg::SRC_STREAM, 1'b0, 4'd0), take_bits(32));
        write_col(1, 3'd7, make_ctrl(stream_pipe_pkg::OP_PASS, stream_pipe_pkg::SRC_INBOUND,
                                     stream_pipe_pkg::SRC_STREAM, 1'b0, 4'd0), take_bits(32));
        write_col(2, 3'd7, make_ctrl(stream_pipe_pkg::OP_XOR, stream_pipe_pkg::SRC_STREAM,
                                     stream_pipe_pkg::SRC_IMM, 1'b0, 4'd0), take_bits(32));
        // Back and forth between the two rows
        for (int b = 0; b < 3; b++) begin
            set_prog((b % 2 == 0) ? 3'd6 : 3'd7);
            send_burst(N_SW);
            drain();
        end
        end_test();
    endtask

    // Accumulator program again, bubbles must not write RF
    task automatic test_bubbles_state();
        start_test("bubbles_state");
        set_prog(3'd5);
        for (int i = 0; i < N_MIX; i++) send_item(take_bits(1) != 0, take_bits(32), take_bits(32));
        tick();
        in_valid = 1'b0;
        drain();
        if (seen_cnt != sent_cnt) begin
            $display("ERR %s: expected %0d, actual %0d", cur_test, sent_cnt, seen_cnt);
            test_err++;
        end
        if (state.item_count !== m_count) begin
            $display("ERR %s: expected %h, actual %h", cur_test, m_count, state.item_count);
            test_err++;
        end
        if (state.checksum !== m_csum) begin
            $display("ERR %s: expected %h, actual %h", cur_test, m_csum, state.checksum);
            test_err++;
        end
        end_test();
    endtask

    //////////////////////////////////////////////////
    // Main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        inbound     = '0;
        stream_in   = '0;
        prog_sel    = '0;
        cfg_wr_addr = '0;
        cfg_wr_en   = '0;
        cfg_wr_data = '0;
        cyc         = 0;
        lfsr        = 32'h6fc9_4ab4;
        m_sel       = '0;
        m_count     = '0;
        m_csum      = '0;
        pass_cnt    = 0;
        fail_cnt    = 0;
        for (int c = 0; c < NCOL; c++) begin
            for (int a = 0; a < PROG_DEPTH; a++) begin
                m_ctrl[c][a] = '0;
                m_imm[c][a]  = '0;
            end
            for (int r = 0; r < 16; r++) m_rf[c][r] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;
        test_reset_defaults();
        test_operand_ops();
        test_rf_accum();
        test_prog_switch();
        test_bubbles_state();
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
hdl/stream_pipe_pkg.sv
hdl/ctrl_plane.sv
hdl/column_stage.sv
hdl/stream_result.sv
hdl/stream_pipe_top.sv
tb/tb_stream_pipe.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the stream pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_stream_pipe \
    -f filelist.f \
    --Mdir obj_dir

./obj_dir/Vtb_stream_pipe > sim.log 2>&1
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "STATUS: PASS" sim.log; then
    echo "simulation ended without a status line"
    exit 1
fi

exit 0
